// ==== axil_mem_share.f ====
+incdir+testbench
design/axil_mem_pkg.sv
design/axil_arbiter.sv
design/axil_sram.sv
design/ifu_fetch_port.sv
design/lsu_mem_port.sv
design/axil_mem_top.sv
testbench/tb_axil_mem_top.sv

// ==== design/axil_arbiter.sv ====
`default_nettype none

module axil_arbiter (
    input  wire                                 CLK,
    input  wire                                 RESETN,
    input  wire                                 ifu_awvalid,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] ifu_awaddr,
    output logic                                ifu_awready,
    input  wire                                 ifu_wvalid,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] ifu_wdata,
    input  wire  [axil_mem_pkg::STRB_WIDTH-1:0] ifu_wstrb,
    output logic                                ifu_wready,
    output logic                                ifu_bvalid,
    output logic [1:0]                          ifu_bresp,
    input  wire                                 ifu_bready,
    input  wire                                 ifu_arvalid,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] ifu_araddr,
    output logic                                ifu_arready,
    output logic                                ifu_rvalid,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] ifu_rdata,
    output logic [1:0]                          ifu_rresp,
    input  wire                                 ifu_rready,
    input  wire                                 lsu_awvalid,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] lsu_awaddr,
    output logic                                lsu_awready,
    input  wire                                 lsu_wvalid,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] lsu_wdata,
    input  wire  [axil_mem_pkg::STRB_WIDTH-1:0] lsu_wstrb,
    output logic                                lsu_wready,
    output logic                                lsu_bvalid,
    output logic [1:0]                          lsu_bresp,
    input  wire                                 lsu_bready,
    input  wire                                 lsu_arvalid,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] lsu_araddr,
    output logic                                lsu_arready,
    output logic                                lsu_rvalid,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] lsu_rdata,
    output logic [1:0]                          lsu_rresp,
    input  wire                                 lsu_rready,
    output logic                                sram_awvalid,
    output logic [axil_mem_pkg::ADDR_WIDTH-1:0] sram_awaddr,
    input  wire                                 sram_awready,
    output logic                                sram_wvalid,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] sram_wdata,
    output logic [axil_mem_pkg::STRB_WIDTH-1:0] sram_wstrb,
    input  wire                                 sram_wready,
    input  wire                                 sram_bvalid,
    input  wire  [1:0]                          sram_bresp,
    output logic                                sram_bready,
    output logic                                sram_arvalid,
    output logic [axil_mem_pkg::ADDR_WIDTH-1:0] sram_araddr,
    input  wire                                 sram_arready,
    input  wire                                 sram_rvalid,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] sram_rdata,
    input  wire  [1:0]                          sram_rresp,
    output logic                                sram_rready
);

    logic [1:0] state;
    logic       sel_ifu, sel_lsu;
    logic       done_hs;

    assign sel_ifu = (state == axil_mem_pkg::GNT_IFU);
    assign sel_lsu = (state == axil_mem_pkg::GNT_LSU);
    assign done_hs = (sram_bvalid && sram_bready) || (sram_rvalid && sram_rready);

    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            state <= axil_mem_pkg::GNT_IDLE;
        end else begin
            case (state)
                axil_mem_pkg::GNT_IDLE: begin
                    if (ifu_awvalid || ifu_arvalid) begin  // ifu always first
                        state <= axil_mem_pkg::GNT_IFU;
                    end else if (lsu_awvalid || lsu_arvalid) begin
                        state <= axil_mem_pkg::GNT_LSU;
                    end
                end
                axil_mem_pkg::GNT_IFU, axil_mem_pkg::GNT_LSU: begin
                    if (done_hs) begin  // release only on completed B or R
                        state <= axil_mem_pkg::GNT_IDLE;
                    end
                end
                default: state <= axil_mem_pkg::GNT_IDLE;
            endcase
        end
    end

    // granted master to sram
    assign sram_awvalid = sel_ifu ? ifu_awvalid : (sel_lsu && lsu_awvalid);
    assign sram_awaddr  = sel_ifu ? ifu_awaddr  : (sel_lsu ? lsu_awaddr : '0);
    assign sram_wvalid  = sel_ifu ? ifu_wvalid  : (sel_lsu && lsu_wvalid);
    assign sram_wdata   = sel_ifu ? ifu_wdata   : (sel_lsu ? lsu_wdata : '0);
    assign sram_wstrb   = sel_ifu ? ifu_wstrb   : (sel_lsu ? lsu_wstrb : '0);
    assign sram_bready  = sel_ifu ? ifu_bready  : (sel_lsu && lsu_bready);
    assign sram_arvalid = sel_ifu ? ifu_arvalid : (sel_lsu && lsu_arvalid);
    assign sram_araddr  = sel_ifu ? ifu_araddr  : (sel_lsu ? lsu_araddr : '0);
    assign sram_rready  = sel_ifu ? ifu_rready  : (sel_lsu && lsu_rready);

    // sram back to the granted master and zeros to the other
    assign ifu_awready = sel_ifu && sram_awready;
    assign ifu_wready  = sel_ifu && sram_wready;
    assign ifu_bvalid  = sel_ifu && sram_bvalid;
    assign ifu_bresp   = sel_ifu ? sram_bresp : '0;
    assign ifu_arready = sel_ifu && sram_arready;
    assign ifu_rvalid  = sel_ifu && sram_rvalid;
    assign ifu_rdata   = sel_ifu ? sram_rdata : '0;
    assign ifu_rresp   = sel_ifu ? sram_rresp : '0;

    assign lsu_awready = sel_lsu && sram_awready;
    assign lsu_wready  = sel_lsu && sram_wready;
    assign lsu_bvalid  = sel_lsu && sram_bvalid;
    assign lsu_bresp   = sel_lsu ? sram_bresp : '0;
    assign lsu_arready = sel_lsu && sram_arready;
    assign lsu_rvalid  = sel_lsu && sram_rvalid;
    assign lsu_rdata   = sel_lsu ? sram_rdata : '0;
    assign lsu_rresp   = sel_lsu ? sram_rresp : '0;

    // no sram response once the grant is gone
    a_idle_quiet: assert property (@(posedge CLK) disable iff (!RESETN)
        state == axil_mem_pkg::GNT_IDLE |-> !(sram_bvalid || sram_rvalid));

    a_grant_held: assert property (@(posedge CLK) disable iff (!RESETN)
        (sram_bvalid || sram_rvalid) |-> state == $past(state));

endmodule

`default_nettype wire

// ==== design/axil_mem_pkg.sv ====
`default_nettype none

package axil_mem_pkg;

    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;  // one per byte

    localparam int SRAM_WORDS = 256;  // 1 KiB
    localparam int SRAM_LAT   = 2;    // accept to response valid

    localparam logic [1:0] RESP_OKAY   = 2'd0;
    localparam logic [1:0] RESP_SLVERR = 2'd2;

    // arbiter grant encodings
    localparam logic [1:0] GNT_IDLE = 2'd0;
    localparam logic [1:0] GNT_IFU  = 2'd1;
    localparam logic [1:0] GNT_LSU  = 2'd2;

endpackage

`default_nettype wire

// ==== design/axil_mem_top.sv ====
`default_nettype none

module axil_mem_top (
    input  wire                                 CLK,
    input  wire                                 RESETN,
    input  wire                                 fetch_req,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] fetch_pc,
    output logic                                fetch_busy,
    output logic                                fetch_done,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] fetch_inst,
    output logic                                fetch_err,
    input  wire                                 ls_req,
    input  wire                                 ls_write,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] ls_addr,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] ls_wdata,
    input  wire  [axil_mem_pkg::STRB_WIDTH-1:0] ls_wstrb,
    output logic                                ls_busy,
    output logic                                ls_done,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] ls_rdata,
    output logic                                ls_err
);

    // fetch master link
    logic ifu_awvalid, ifu_awready, ifu_wvalid, ifu_wready, ifu_bvalid;
    logic ifu_bready, ifu_arvalid, ifu_arready, ifu_rvalid, ifu_rready;
    logic [axil_mem_pkg::ADDR_WIDTH-1:0] ifu_awaddr, ifu_araddr;
    logic [axil_mem_pkg::DATA_WIDTH-1:0] ifu_wdata, ifu_rdata;
    logic [axil_mem_pkg::STRB_WIDTH-1:0] ifu_wstrb;
    logic [1:0]                          ifu_bresp, ifu_rresp;

    // load/store master link
    logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bvalid;
    logic lsu_bready, lsu_arvalid, lsu_arready, lsu_rvalid, lsu_rready;
    logic [axil_mem_pkg::ADDR_WIDTH-1:0] lsu_awaddr, lsu_araddr;
    logic [axil_mem_pkg::DATA_WIDTH-1:0] lsu_wdata, lsu_rdata;
    logic [axil_mem_pkg::STRB_WIDTH-1:0] lsu_wstrb;
    logic [1:0]                          lsu_bresp, lsu_rresp;

    // shared sram link
    logic sram_awvalid, sram_awready, sram_wvalid, sram_wready, sram_bvalid;
    logic sram_bready, sram_arvalid, sram_arready, sram_rvalid, sram_rready;
    logic [axil_mem_pkg::ADDR_WIDTH-1:0] sram_awaddr, sram_araddr;
    logic [axil_mem_pkg::DATA_WIDTH-1:0] sram_wdata, sram_rdata;
    logic [axil_mem_pkg::STRB_WIDTH-1:0] sram_wstrb;
    logic [1:0]                          sram_bresp, sram_rresp;

    ifu_fetch_port i_ifu_fetch_port (.*);

    lsu_mem_port i_lsu_mem_port (.*);

    axil_arbiter i_axil_arbiter (.*);  // ifu has fixed priority

    axil_sram i_axil_sram (.*);

endmodule

`default_nettype wire

// ==== design/axil_sram.sv ====
`default_nettype none

module axil_sram (
    input  wire                                 CLK,
    input  wire                                 RESETN,
    input  wire                                 sram_awvalid,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] sram_awaddr,
    output logic                                sram_awready,
    input  wire                                 sram_wvalid,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] sram_wdata,
    input  wire  [axil_mem_pkg::STRB_WIDTH-1:0] sram_wstrb,
    output logic                                sram_wready,
    output logic                                sram_bvalid,
    output logic [1:0]                          sram_bresp,
    input  wire                                 sram_bready,
    input  wire                                 sram_arvalid,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] sram_araddr,
    output logic                                sram_arready,
    output logic                                sram_rvalid,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] sram_rdata,
    output logic [1:0]                          sram_rresp,
    input  wire                                 sram_rready
);

    logic [axil_mem_pkg::DATA_WIDTH-1:0]          mem [axil_mem_pkg::SRAM_WORDS];
    logic [$clog2(axil_mem_pkg::SRAM_WORDS)-1:0]  aw_idx, ar_idx;
    logic [$clog2(axil_mem_pkg::SRAM_LAT + 1)-1:0] cnt;
    logic                                         aw_ok, ar_ok;
    logic                                         busy, is_wr, resp_valid;
    logic [1:0]                                   resp_q;

    assign aw_idx = sram_awaddr[2 +: $bits(aw_idx)];
    assign ar_idx = sram_araddr[2 +: $bits(ar_idx)];
    assign aw_ok  = sram_awaddr < axil_mem_pkg::SRAM_WORDS * 4;
    assign ar_ok  = sram_araddr < axil_mem_pkg::SRAM_WORDS * 4;

    // write wins when both are presented
    assign sram_awready = !busy && sram_awvalid && sram_wvalid;
    assign sram_wready  = sram_awready;
    assign sram_arready = !busy && sram_arvalid && !(sram_awvalid && sram_wvalid);

    assign resp_valid  = busy && (cnt == '0);
    assign sram_bvalid = resp_valid && is_wr;
    assign sram_rvalid = resp_valid && !is_wr;
    assign sram_bresp  = resp_q;
    assign sram_rresp  = resp_q;

    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            busy  <= 1'b0;
            is_wr <= 1'b0;
            cnt   <= '0;
        end else if (sram_awready || sram_arready) begin
            busy  <= 1'b1;
            is_wr <= sram_awready;
            cnt   <= $bits(cnt)'(axil_mem_pkg::SRAM_LAT - 1);
        end else if (busy && cnt != '0) begin
            cnt <= cnt - 1'b1;
        end else if ((sram_bvalid && sram_bready) || (sram_rvalid && sram_rready)) begin
            busy <= 1'b0;  // held until the master takes it
        end
    end

    always_ff @(posedge CLK) begin
        if (sram_awready) begin
            resp_q <= aw_ok ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
            if (aw_ok) begin
                for (int b = 0; b < axil_mem_pkg::STRB_WIDTH; b++) begin
                    if (sram_wstrb[b]) begin
                        mem[aw_idx][8*b +: 8] <= sram_wdata[8*b +: 8];
                    end
                end
            end
        end else if (sram_arready) begin
            resp_q     <= ar_ok ? axil_mem_pkg::RESP_OKAY : axil_mem_pkg::RESP_SLVERR;
            sram_rdata <= ar_ok ? mem[ar_idx] : '0;  // zero on bad address
        end
    end

    // response rises a fixed latency after acceptance
    a_resp_lat: assert property (@(posedge CLK) disable iff (!RESETN)
        $rose(sram_bvalid || sram_rvalid)
            |-> $past(sram_awready || sram_arready, axil_mem_pkg::SRAM_LAT));

endmodule

`default_nettype wire

// ==== design/ifu_fetch_port.sv ====
`default_nettype none

module ifu_fetch_port (
    input  wire                                 CLK,
    input  wire                                 RESETN,
    input  wire                                 fetch_req,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] fetch_pc,
    output logic                                fetch_busy,
    output logic                                fetch_done,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] fetch_inst,
    output logic                                fetch_err,
    output logic                                ifu_awvalid,
    output logic [axil_mem_pkg::ADDR_WIDTH-1:0] ifu_awaddr,
    input  wire                                 ifu_awready,
    output logic                                ifu_wvalid,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] ifu_wdata,
    output logic [axil_mem_pkg::STRB_WIDTH-1:0] ifu_wstrb,
    input  wire                                 ifu_wready,
    input  wire                                 ifu_bvalid,
    input  wire  [1:0]                          ifu_bresp,
    output logic                                ifu_bready,
    output logic                                ifu_arvalid,
    output logic [axil_mem_pkg::ADDR_WIDTH-1:0] ifu_araddr,
    input  wire                                 ifu_arready,
    input  wire                                 ifu_rvalid,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] ifu_rdata,
    input  wire  [1:0]                          ifu_rresp,
    output logic                                ifu_rready
);

    // fetch is read only
    assign ifu_awvalid = 1'b0;
    assign ifu_awaddr  = '0;
    assign ifu_wvalid  = 1'b0;
    assign ifu_wdata   = '0;
    assign ifu_wstrb   = '0;
    assign ifu_bready  = 1'b1;
    assign ifu_rready  = 1'b1;  // no back-pressure

    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            fetch_busy  <= 1'b0;
            fetch_done  <= 1'b0;
            ifu_arvalid <= 1'b0;
        end else begin
            fetch_done <= ifu_rvalid && ifu_rready;
            if (fetch_req && !fetch_busy) begin
                fetch_busy  <= 1'b1;
                ifu_arvalid <= 1'b1;
            end else begin
                if (ifu_arvalid && ifu_arready) begin
                    ifu_arvalid <= 1'b0;
                end
                if (ifu_rvalid && ifu_rready) begin
                    fetch_busy <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (fetch_req && !fetch_busy) begin
            ifu_araddr <= fetch_pc;
        end
        if (ifu_rvalid && ifu_rready) begin
            fetch_inst <= ifu_rdata;
            fetch_err  <= ifu_rresp != axil_mem_pkg::RESP_OKAY;
        end
    end

    a_req_idle: assert property (@(posedge CLK) disable iff (!RESETN)
        fetch_req |-> !fetch_busy);

    // the arbiter must never route write traffic here
    a_no_write: assert property (@(posedge CLK) disable iff (!RESETN)
        !(ifu_awready || ifu_wready || ifu_bvalid));

endmodule

`default_nettype wire

// ==== design/lsu_mem_port.sv ====
`default_nettype none

module lsu_mem_port (
    input  wire                                 CLK,
    input  wire                                 RESETN,
    input  wire                                 ls_req,
    input  wire                                 ls_write,
    input  wire  [axil_mem_pkg::ADDR_WIDTH-1:0] ls_addr,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] ls_wdata,
    input  wire  [axil_mem_pkg::STRB_WIDTH-1:0] ls_wstrb,
    output logic                                ls_busy,
    output logic                                ls_done,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] ls_rdata,
    output logic                                ls_err,
    output logic                                lsu_awvalid,
    output logic [axil_mem_pkg::ADDR_WIDTH-1:0] lsu_awaddr,
    input  wire                                 lsu_awready,
    output logic                                lsu_wvalid,
    output logic [axil_mem_pkg::DATA_WIDTH-1:0] lsu_wdata,
    output logic [axil_mem_pkg::STRB_WIDTH-1:0] lsu_wstrb,
    input  wire                                 lsu_wready,
    input  wire                                 lsu_bvalid,
    input  wire  [1:0]                          lsu_bresp,
    output logic                                lsu_bready,
    output logic                                lsu_arvalid,
    output logic [axil_mem_pkg::ADDR_WIDTH-1:0] lsu_araddr,
    input  wire                                 lsu_arready,
    input  wire                                 lsu_rvalid,
    input  wire  [axil_mem_pkg::DATA_WIDTH-1:0] lsu_rdata,
    input  wire  [1:0]                          lsu_rresp,
    output logic                                lsu_rready
);

    logic start, r_hs, b_hs;

    assign start      = ls_req && !ls_busy;
    assign r_hs       = lsu_rvalid && lsu_rready;
    assign b_hs       = lsu_bvalid && lsu_bready;
    assign lsu_bready = 1'b1;
    assign lsu_rready = 1'b1;
    assign lsu_araddr = lsu_awaddr;  // one latched address serves both

    always_ff @(posedge CLK or negedge RESETN) begin
        if (!RESETN) begin
            ls_busy     <= 1'b0;
            ls_done     <= 1'b0;
            lsu_awvalid <= 1'b0;
            lsu_wvalid  <= 1'b0;
            lsu_arvalid <= 1'b0;
        end else begin
            ls_done <= r_hs || b_hs;
            if (start) begin
                ls_busy     <= 1'b1;
                lsu_awvalid <= ls_write;
                lsu_wvalid  <= ls_write;
                lsu_arvalid <= !ls_write;
            end else begin
                if (lsu_awready) lsu_awvalid <= 1'b0;  // aw and w drop on their own
                if (lsu_wready) lsu_wvalid <= 1'b0;
                if (lsu_arready) lsu_arvalid <= 1'b0;
                if (r_hs || b_hs) ls_busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLK) begin
        if (start) begin
            lsu_awaddr <= ls_addr;
            lsu_wdata  <= ls_wdata;
            lsu_wstrb  <= ls_wstrb;
        end
        if (r_hs) begin
            ls_rdata <= lsu_rdata;
            ls_err   <= lsu_rresp != axil_mem_pkg::RESP_OKAY;
        end else if (b_hs) begin
            ls_err <= lsu_bresp != axil_mem_pkg::RESP_OKAY;
        end
    end

    a_one_dir: assert property (@(posedge CLK) disable iff (!RESETN)
        !(lsu_awvalid && lsu_arvalid));

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/bin/sh
# build and run the shared memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_axil_mem_top -Mdir obj_dir -o tb_axil_mem_top \
    -f axil_mem_share.f
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_axil_mem_top > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test FAILED" "$LOG"; then
    exit 1
fi
exit 0

// ==== testbench/tb_axil_mem_tasks.svh ====
`ifndef TB_AXIL_MEM_TASKS_SVH
`define TB_AXIL_MEM_TASKS_SVH

task automatic report_mismatch(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
    $display("MISMATCH %s: expected %h actual %h", name, expected, actual);
    mismatch_count++;
endtask

function automatic logic [$clog2(axil_mem_pkg::SRAM_WORDS)-1:0] word_index(
        input logic [axil_mem_pkg::ADDR_WIDTH-1:0] addr);
    return addr[2 +: $clog2(axil_mem_pkg::SRAM_WORDS)];
endfunction

function automatic logic expected_err(input logic [axil_mem_pkg::ADDR_WIDTH-1:0] addr);
    return addr >= 32'(axil_mem_pkg::SRAM_WORDS * 4);
endfunction

function automatic logic [31:0] expected_read(input logic [axil_mem_pkg::ADDR_WIDTH-1:0] addr);
    if (expected_err(addr)) begin
        return '0;  // sram answers zero data
    end
    return model[word_index(addr)];
endfunction

// merge strobed bytes, out of range writes are dropped
function automatic void apply_store(input logic [axil_mem_pkg::ADDR_WIDTH-1:0] addr,
                                    input logic [axil_mem_pkg::DATA_WIDTH-1:0] data,
                                    input logic [axil_mem_pkg::STRB_WIDTH-1:0] strb);
    if (!expected_err(addr)) begin
        for (int b = 0; b < axil_mem_pkg::STRB_WIDTH; b++) begin
            if (strb[b]) begin
                model[word_index(addr)][8*b +: 8] = data[8*b +: 8];
            end
        end
    end
endfunction

function automatic logic [31:0] test_addr(input int n);
    return 32'(n * 60 + 8);  // spread over the sram
endfunction

// one cycle strobe, then busy must be up
task automatic issue_request(input string name, input logic use_fetch);
    @(posedge CLK);
    #1;
    fetch_req = 1'b0;
    ls_req    = 1'b0;
    if (use_fetch && fetch_busy !== 1'b1) begin
        report_mismatch({name, " fetch_busy"}, 32'd1, 32'(fetch_busy));
    end
    if (!use_fetch && ls_busy !== 1'b1) begin
        report_mismatch({name, " ls_busy"}, 32'd1, 32'(ls_busy));
    end
endtask

task automatic wait_done(input string name, input logic use_fetch, output logic seen);
    int   cycles;
    logic busy;
    seen   = 1'b0;
    busy   = 1'b0;
    cycles = 0;
    while (!seen && cycles < 100) begin
        @(posedge CLK);
        #1;
        cycles++;
        seen = use_fetch ? (fetch_done === 1'b1) : (ls_done === 1'b1);
        busy = use_fetch ? fetch_busy : ls_busy;
    end
    if (!seen) begin
        $display("%s: no done pulse within 100 cycles", name);
        failure_count++;
    end else if (busy !== 1'b0) begin
        report_mismatch({name, " busy at done"}, 32'd0, 32'(busy));
    end
endtask

task automatic lsu_store(input string name, input logic [31:0] addr, input logic [31:0] data,
                         input logic [axil_mem_pkg::STRB_WIDTH-1:0] strb);
    logic seen;
    ls_req   = 1'b1;
    ls_write = 1'b1;
    ls_addr  = addr;
    ls_wdata = data;
    ls_wstrb = strb;
    issue_request(name, 1'b0);
    wait_done(name, 1'b0, seen);
    if (seen && ls_err !== expected_err(addr)) begin
        report_mismatch({name, " ls_err"}, 32'(expected_err(addr)), 32'(ls_err));
    end
    apply_store(addr, data, strb);
endtask

task automatic lsu_load(input string name, input logic [31:0] addr);
    logic seen;
    ls_req   = 1'b1;
    ls_write = 1'b0;
    ls_addr  = addr;
    issue_request(name, 1'b0);
    wait_done(name, 1'b0, seen);
    if (seen) begin
        if (ls_rdata !== expected_read(addr)) begin
            report_mismatch(name, expected_read(addr), ls_rdata);
        end
        if (ls_err !== expected_err(addr)) begin
            report_mismatch({name, " ls_err"}, 32'(expected_err(addr)), 32'(ls_err));
        end
    end
endtask

task automatic ifu_fetch(input string name, input logic [31:0] pc);
    logic seen;
    fetch_req = 1'b1;
    fetch_pc  = pc;
    issue_request(name, 1'b1);
    wait_done(name, 1'b1, seen);
    if (seen) begin
        if (fetch_inst !== expected_read(pc)) begin
            report_mismatch(name, expected_read(pc), fetch_inst);
        end
        if (fetch_err !== expected_err(pc)) begin
            report_mismatch({name, " fetch_err"}, 32'(expected_err(pc)), 32'(fetch_err));
        end
    end
endtask

task automatic store_then_load();
    for (int n = 0; n < 16; n++) begin
        lsu_store("store_load write", test_addr(n), $random(seed), 4'hF);
    end
    for (int n = 0; n < 16; n++) begin
        lsu_load("store_load read", test_addr(n));
    end
endtask

task automatic byte_strobes();
    lsu_store("strobe base", 32'h3F0, 32'h1122_3344, 4'hF);
    lsu_load("strobe base", 32'h3F0);
    lsu_store("strobe 0101", 32'h3F0, $random(seed), 4'b0101);
    lsu_load("strobe 0101", 32'h3F0);
    lsu_store("strobe 1000", 32'h3F0, $random(seed), 4'b1000);
    lsu_load("strobe 1000", 32'h3F0);
    lsu_store("strobe 0010", 32'h3F0, $random(seed), 4'b0010);
    lsu_load("strobe 0010", 32'h3F0);
endtask

task automatic fetch_written_words();
    ifu_fetch("fetch", test_addr(0));
    ifu_fetch("fetch", test_addr(3));
    ifu_fetch("fetch", test_addr(7));
    ifu_fetch("fetch", test_addr(12));
    ifu_fetch("fetch", 32'h3F0);
endtask

// same cycle requests, ifu must win the bus
task automatic fetch_and_load(input string name, input logic [31:0] pc,
                              input logic [31:0] addr);
    int cycles;
    int fetch_at;
    int load_at;
    cycles    = 0;
    fetch_at  = 0;
    load_at   = 0;
    fetch_req = 1'b1;
    fetch_pc  = pc;
    ls_req    = 1'b1;
    ls_write  = 1'b0;
    ls_addr   = addr;
    @(posedge CLK);
    #1;
    fetch_req = 1'b0;
    ls_req    = 1'b0;
    while ((fetch_at == 0 || load_at == 0) && cycles < 100) begin
        @(posedge CLK);
        #1;
        cycles++;
        if (fetch_done === 1'b1) begin
            fetch_at = cycles;
            if (fetch_inst !== expected_read(pc)) begin
                report_mismatch({name, " fetch"}, expected_read(pc), fetch_inst);
            end
        end
        if (ls_done === 1'b1) begin
            load_at = cycles;
            if (ls_rdata !== expected_read(addr)) begin
                report_mismatch({name, " load"}, expected_read(addr), ls_rdata);
            end
        end
    end
    if (fetch_at == 0 || load_at == 0) begin
        $display("%s: a done pulse did not arrive within 100 cycles", name);
        failure_count++;
    end else if (fetch_at >= load_at) begin
        $display("%s: the load finished before the fetch", name);
        failure_count++;
    end
endtask

task automatic contention();
    fetch_and_load("contention", test_addr(2), test_addr(9));
    fetch_and_load("contention", 32'h3F0, test_addr(14));
endtask

task automatic out_of_range();
    lsu_load("oor load", 32'(axil_mem_pkg::SRAM_WORDS * 4));
    lsu_store("oor store", 32'h408, 32'hDEAD_BEEF, 4'hF);  // aliases word 2
    ifu_fetch("oor fetch", 32'h800);
    ifu_fetch("oor fetch top", 32'hFFFF_FFFC);
    lsu_load("oor unchanged", 32'h8);
endtask

`endif

// ==== testbench/tb_axil_mem_top.sv ====
`default_nettype none

module tb_axil_mem_top;

    timeunit 1ns;
    timeprecision 100ps;

    logic                                CLK;
    logic                                RESETN;
    logic                                fetch_req;
    logic [axil_mem_pkg::ADDR_WIDTH-1:0] fetch_pc;
    logic                                fetch_busy;
    logic                                fetch_done;
    logic [axil_mem_pkg::DATA_WIDTH-1:0] fetch_inst;
    logic                                fetch_err;
    logic                                ls_req;
    logic                                ls_write;
    logic [axil_mem_pkg::ADDR_WIDTH-1:0] ls_addr;
    logic [axil_mem_pkg::DATA_WIDTH-1:0] ls_wdata;
    logic [axil_mem_pkg::STRB_WIDTH-1:0] ls_wstrb;
    logic                                ls_busy;
    logic                                ls_done;
    logic [axil_mem_pkg::DATA_WIDTH-1:0] ls_rdata;
    logic                                ls_err;

    logic [axil_mem_pkg::DATA_WIDTH-1:0] model [axil_mem_pkg::SRAM_WORDS];  // expected contents
    integer                              seed;
    int                                  mismatch_count;
    int                                  failure_count;

    axil_mem_top i_axil_mem_top (.*);

    always #4 CLK = ~CLK;

    `include "tb_axil_mem_tasks.svh"

    initial begin
        seed           = 55;
        mismatch_count = 0;
        failure_count  = 0;
        CLK            = 1'b0;
        RESETN         = 1'b0;
        fetch_req      = 1'b0;
        fetch_pc       = '0;
        ls_req         = 1'b0;
        ls_write       = 1'b0;
        ls_addr        = '0;
        ls_wdata       = '0;
        ls_wstrb       = '0;

        repeat (8) @(posedge CLK);
        #1;
        RESETN = 1'b1;
        @(posedge CLK);
        #1;

        // both requesters idle out of reset
        if (fetch_busy !== 1'b0) begin
            report_mismatch("reset fetch_busy", 32'd0, 32'(fetch_busy));
        end
        if (ls_busy !== 1'b0) begin
            report_mismatch("reset ls_busy", 32'd0, 32'(ls_busy));
        end

        store_then_load();
        byte_strobes();
        fetch_written_words();
        contention();
        out_of_range();

        $display("errors: %0d mismatches, %0d other failures", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
